// ==== design/arm_pkg.sv ====
// Core package with the word, register, opcode and pipeline payload types
package arm_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  // Values 0..7 and 12..15 line up with the instruction opcode field
  typedef enum logic [3:0] {
    alu_and = 4'h0,
    alu_eor = 4'h1,
    alu_sub = 4'h2,
    alu_rsb = 4'h3,
    alu_add = 4'h4,
    alu_adc = 4'h5,
    alu_sbc = 4'h6,
    alu_rsc = 4'h7,
    alu_orr = 4'hc,
    alu_mov = 4'hd,
    alu_bic = 4'he,
    alu_mvn = 4'hf
  } alu_op_e;

  typedef enum logic [3:0] {
    eq, ne, cs, cc, mi, pl, vs, vc,
    hi, ls, ge, lt, gt, le, al, nv
  } cond_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    word_t pc_next;  // Fetch address plus 4
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    alu_op_e     alu_op;
    logic        set_flags;
    logic        rf_write;
    logic        is_branch;
    cond_e       cond;
    reg_idx_t    rd;
    word_t       op_a;
    word_t       op_m;
    logic        imm_mode;
    logic [11:0] shift_field;  // Instruction bits 11:0
    word_t       target;
  } id_ex_t;

  typedef struct packed {
    logic     rf_write;
    reg_idx_t rd;
    word_t    result;
  } ex_wb_t;

endpackage

// ==== design/arm_fetch.sv ====
// Fetch stage holding the program counter with branch redirect and hold
module arm_fetch #(
  parameter arm_pkg::word_t pc_reset = '0
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           fetch_valid,
  input  logic           redirect,
  input  arm_pkg::word_t target,
  output arm_pkg::word_t fetch_addr,
  output arm_pkg::word_t pc_next
);

  logic [31:0] pc;

  assign fetch_addr = pc;
  assign pc_next    = pc + 32'd4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= pc_reset;
    end else if (redirect) begin
      pc <= target;  // Taken branch wins over sequential fetch
    end else if (fetch_valid) begin
      pc <= pc_next;
    end
  end

endmodule

// ==== design/arm_pipe_reg.sv ====
// Pipeline stage register with a valid bit and flush
module arm_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid & ~flush;  // Flush turns the slot into a bubble
    end
  end

  always_ff @(posedge clk) begin
    out_data <= in_data;
  end

endmodule

// ==== design/arm_decode.sv ====
// Instruction decoder producing the execute control fields and branch target
module arm_decode (
  input  arm_pkg::fetch_pkt_t if_id,
  input  arm_pkg::word_t      op_a,
  input  arm_pkg::word_t      op_m,
  output arm_pkg::reg_idx_t   rn,
  output arm_pkg::reg_idx_t   rm,
  output arm_pkg::id_ex_t     id_ex
);
  import arm_pkg::*;

  word_t      instr;
  logic [3:0] opcode;
  logic       is_dp;
  logic       is_b;
  logic       is_cmp;
  word_t      offset;

  assign instr  = if_id.instr;
  assign opcode = instr[24:21];
  assign rn     = instr[19:16];
  assign rm     = instr[3:0];
  assign is_dp  = (instr[27:26] == 2'b00);   // Bit 25 picks the operand form
  assign is_b   = (instr[27:25] == 3'b101);
  assign is_cmp = (opcode[3:2] == 2'b10);    // TST TEQ CMP CMN
  assign offset = {{6{instr[23]}}, instr[23:0], 2'b00};

  always_comb begin
    case (opcode)
      4'h0, 4'h8: id_ex.alu_op = alu_and;
      4'h1, 4'h9: id_ex.alu_op = alu_eor;
      4'h2, 4'ha: id_ex.alu_op = alu_sub;
      4'h3:       id_ex.alu_op = alu_rsb;
      4'h4, 4'hb: id_ex.alu_op = alu_add;
      4'h5:       id_ex.alu_op = alu_adc;
      4'h6:       id_ex.alu_op = alu_sbc;
      4'h7:       id_ex.alu_op = alu_rsc;
      4'hc:       id_ex.alu_op = alu_orr;
      4'hd:       id_ex.alu_op = alu_mov;
      4'he:       id_ex.alu_op = alu_bic;
      default:    id_ex.alu_op = alu_mvn;
    endcase

    // Anything outside data processing and B retires without effect
    id_ex.set_flags = is_dp & (instr[20] | is_cmp);
    id_ex.rf_write  = is_dp & ~is_cmp;
    id_ex.is_branch = is_b;

    id_ex.cond        = cond_e'(instr[31:28]);  // Only used by branches
    id_ex.rd          = instr[15:12];
    id_ex.op_a        = op_a;
    id_ex.op_m        = op_m;
    id_ex.imm_mode    = instr[25];
    id_ex.shift_field = instr[11:0];
    id_ex.target      = if_id.pc_next + offset;
  end

endmodule

// ==== design/arm_regfile.sv ====
// Register file of sixteen 32-bit registers, two read ports and one write port
module arm_regfile (
  input  logic              clk,
  input  logic              reset,
  input  arm_pkg::reg_idx_t rn,
  input  arm_pkg::reg_idx_t rm,
  input  logic              we,
  input  arm_pkg::reg_idx_t wa,
  input  arm_pkg::word_t    wd,
  output arm_pkg::word_t    rd_n,
  output arm_pkg::word_t    rd_m
);
  import arm_pkg::*;

  word_t regs [16];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // No internal bypass, same-cycle writes come through forwarding
  assign rd_n = regs[rn];
  assign rd_m = regs[rm];

endmodule

// ==== design/arm_forward.sv ====
// Operand forwarding from execute and writeback into decode
module arm_forward (
  input  arm_pkg::reg_idx_t rn,
  input  arm_pkg::reg_idx_t rm,
  input  arm_pkg::word_t    rd_n,
  input  arm_pkg::word_t    rd_m,
  input  logic              ex_valid,
  input  arm_pkg::ex_wb_t   ex_out,
  input  logic              wb_valid,
  input  arm_pkg::ex_wb_t   wb_out,
  output arm_pkg::word_t    op_a,
  output arm_pkg::word_t    op_m
);
  import arm_pkg::*;

  // Youngest producer first
  function automatic word_t pick(reg_idx_t idx, word_t rf_val);
    word_t val;
    if (ex_valid && ex_out.rf_write && ex_out.rd == idx) begin
      val = ex_out.result;
    end else if (wb_valid && wb_out.rf_write && wb_out.rd == idx) begin
      val = wb_out.result;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  assign op_a = pick(rn, rd_n);
  assign op_m = pick(rm, rd_m);

endmodule

// ==== design/arm_shifter.sv ====
// Barrel shifter for the second ALU operand
module arm_shifter (
  input  arm_pkg::word_t op_m,
  input  logic [11:0]    shift_field,
  input  logic           imm_mode,
  output arm_pkg::word_t op_b
);

  logic [4:0]  amount;
  logic [63:0] rot_src;
  logic [63:0] rot_out;

  always_comb begin
    if (imm_mode) begin
      amount  = {shift_field[11:8], 1'b0};          // Twice the rotate field
      rot_src = {2{24'd0, shift_field[7:0]}};
    end else begin
      amount  = shift_field[11:7];
      rot_src = {op_m, op_m};
    end
    rot_out = rot_src >> amount;

    if (imm_mode || shift_field[6:5] == 2'b11) begin
      op_b = rot_out[31:0];                         // Rotate right
    end else if (amount == 5'd0) begin
      op_b = op_m;
    end else if (shift_field[6:5] == 2'b00) begin
      op_b = op_m << amount;                        // LSL
    end else if (shift_field[6:5] == 2'b01) begin
      op_b = op_m >> amount;                        // LSR
    end else begin
      op_b = $signed(op_m) >>> amount;              // ASR
    end
  end

endmodule

// ==== design/arm_alu.sv ====
// ALU computing the data-processing result and the next condition flags
module arm_alu (
  input  arm_pkg::word_t   a,
  input  arm_pkg::word_t   b,
  input  arm_pkg::alu_op_e op,
  input  arm_pkg::flags_t  flags_in,
  output arm_pkg::word_t   result,
  output arm_pkg::flags_t  flags_out
);
  import arm_pkg::*;

  word_t       add_x;
  word_t       add_y;
  logic        add_cin;
  logic        arith;
  logic [32:0] sum;

  always_comb begin
    // One adder serves all arithmetic, subtraction by inverted operand
    add_x   = a;
    add_y   = b;
    add_cin = 1'b0;
    arith   = 1'b1;
    case (op)
      alu_add: add_cin = 1'b0;
      alu_adc: add_cin = flags_in.c;
      alu_sub: begin
        add_y   = ~b;
        add_cin = 1'b1;
      end
      alu_sbc: begin
        add_y   = ~b;
        add_cin = flags_in.c;  // Carry set means no borrow
      end
      alu_rsb: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = 1'b1;
      end
      alu_rsc: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = flags_in.c;
      end
      default: arith = 1'b0;
    endcase
    sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};

    case (op)
      alu_and: result = a & b;
      alu_eor: result = a ^ b;
      alu_orr: result = a | b;
      alu_mov: result = b;
      alu_bic: result = a & ~b;
      alu_mvn: result = ~b;
      default: result = sum[31:0];
    endcase

    flags_out.n = result[31];
    flags_out.z = (result == '0);
    if (arith) begin
      flags_out.c = sum[32];
      flags_out.v = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);
    end else begin
      flags_out.c = flags_in.c;  // Logical ops keep C and V
      flags_out.v = flags_in.v;
    end
  end

endmodule

// ==== design/arm_branch_cond.sv ====
// Branch condition evaluation against the current flags
module arm_branch_cond (
  input  arm_pkg::cond_e  cond,
  input  arm_pkg::flags_t flags,
  output logic            taken
);
  import arm_pkg::*;

  always_comb begin
    case (cond)
      eq:      taken = flags.z;
      ne:      taken = ~flags.z;
      cs:      taken = flags.c;
      cc:      taken = ~flags.c;
      mi:      taken = flags.n;
      pl:      taken = ~flags.n;
      vs:      taken = flags.v;
      vc:      taken = ~flags.v;
      hi:      taken = flags.c & ~flags.z;
      ls:      taken = ~flags.c | flags.z;
      ge:      taken = (flags.n == flags.v);
      lt:      taken = (flags.n != flags.v);
      gt:      taken = ~flags.z & (flags.n == flags.v);
      le:      taken = flags.z | (flags.n != flags.v);
      al:      taken = 1'b1;
      default: taken = 1'b0;  // nv never branches
    endcase
  end

endmodule

// ==== design/arm_core.sv ====
// Four-stage pipelined core top with fetch, decode, execute and writeback
module arm_core #(
  parameter arm_pkg::word_t pc_reset = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            fetch_valid,
  input  arm_pkg::word_t  fetch_instr,
  output arm_pkg::word_t  fetch_addr,
  output logic            wb_valid,
  output arm_pkg::ex_wb_t wb
);
  import arm_pkg::*;

  word_t      pc_next;
  fetch_pkt_t if_id_d;
  fetch_pkt_t if_id_q;
  logic       if_id_valid;

  reg_idx_t rn;
  reg_idx_t rm;
  word_t    rd_n;
  word_t    rd_m;
  word_t    op_a;
  word_t    op_m;
  id_ex_t   id_ex_d;
  id_ex_t   id_ex_q;
  logic     id_ex_valid;

  word_t  op_b;
  word_t  alu_result;
  flags_t alu_flags;
  flags_t flags;
  logic   taken;
  logic   redirect;
  ex_wb_t ex_wb_d;

  arm_fetch #(.pc_reset(pc_reset)) fetch0 (
    .clk, .reset, .fetch_valid, .redirect,
    .target(id_ex_q.target),
    .fetch_addr, .pc_next
  );

  assign if_id_d = '{pc_next: pc_next, instr: fetch_instr};

  arm_pipe_reg #(.payload_t(fetch_pkt_t)) if_id_reg (
    .clk, .reset,
    .flush(redirect),
    .in_valid(fetch_valid), .in_data(if_id_d),
    .out_valid(if_id_valid), .out_data(if_id_q)
  );

  arm_decode decode0 (
    .if_id(if_id_q), .op_a, .op_m, .rn, .rm,
    .id_ex(id_ex_d)
  );

  arm_regfile regfile0 (
    .clk, .reset, .rn, .rm,
    .we(wb_valid & wb.rf_write), .wa(wb.rd), .wd(wb.result),
    .rd_n, .rd_m
  );

  arm_forward forward0 (
    .rn, .rm, .rd_n, .rd_m,
    .ex_valid(id_ex_valid), .ex_out(ex_wb_d),
    .wb_valid, .wb_out(wb),
    .op_a, .op_m
  );

  arm_pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk, .reset,
    .flush(redirect),
    .in_valid(if_id_valid), .in_data(id_ex_d),
    .out_valid(id_ex_valid), .out_data(id_ex_q)
  );

  arm_shifter shifter0 (
    .op_m(id_ex_q.op_m), .shift_field(id_ex_q.shift_field),
    .imm_mode(id_ex_q.imm_mode), .op_b
  );

  arm_alu alu0 (
    .a(id_ex_q.op_a), .b(op_b), .op(id_ex_q.alu_op),
    .flags_in(flags), .result(alu_result), .flags_out(alu_flags)
  );

  arm_branch_cond branch_cond0 (.cond(id_ex_q.cond), .flags, .taken);

  assign redirect = id_ex_valid & id_ex_q.is_branch & taken;
  assign ex_wb_d  = '{rf_write: id_ex_q.rf_write, rd: id_ex_q.rd, result: alu_result};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (id_ex_valid && !id_ex_q.is_branch && id_ex_q.set_flags) begin
      flags <= alu_flags;  // Visible to the next branch in execute
    end
  end

  arm_pipe_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
    .clk, .reset,
    .flush(1'b0),
    .in_valid(id_ex_valid), .in_data(ex_wb_d),
    .out_valid(wb_valid), .out_data(wb)
  );

endmodule

// ==== include/arm_model.svh ====
// Instruction-level reference model of the core, stepping the program in order
`ifndef ARM_MODEL_SVH
`define ARM_MODEL_SVH

word_t  m_regs [16];
flags_t m_flags;
word_t  m_pc;
ex_wb_t m_writes [$];

function automatic void model_reset();
  for (int i = 0; i < 16; i++) m_regs[i] = '0;
  m_flags = '0;
  m_pc    = '0;
  m_writes.delete();
endfunction

// Pairs of conditions, odd codes are the inverse of the even one
function automatic logic cond_holds(logic [3:0] cond, flags_t f);
  logic t;
  case (cond[3:1])
    3'd0:    t = f.z;
    3'd1:    t = f.c;
    3'd2:    t = f.n;
    3'd3:    t = f.v;
    3'd4:    t = f.c && !f.z;
    3'd5:    t = (f.n == f.v);
    3'd6:    t = !f.z && (f.n == f.v);
    default: t = 1'b1;
  endcase
  return cond[0] ? !t : t;
endfunction

function automatic word_t model_operand2(word_t instr, word_t m);
  int    amt;
  word_t v;
  if (instr[25]) begin
    amt = 2 * int'(instr[11:8]);
    v   = {24'd0, instr[7:0]};
    return (amt == 0) ? v : ((v >> amt) | (v << (32 - amt)));
  end
  amt = int'(instr[11:7]);
  if (amt == 0) return m;
  case (instr[6:5])
    2'b00:   return m << amt;
    2'b01:   return m >> amt;
    2'b10:   return word_t'($signed(m) >>> amt);
    default: return (m >> amt) | (m << (32 - amt));
  endcase
endfunction

function automatic void model_step();
  word_t       instr;
  word_t       a;
  word_t       b;
  word_t       x;
  word_t       y;
  word_t       res;
  logic [3:0]  opc;
  logic [32:0] wide;
  longint      sres;
  logic        arith;
  logic        sub;
  logic        k;
  instr = program_mem[m_pc[9:2]];
  m_pc  = m_pc + 32'd4;
  if (instr[27:25] == 3'b101) begin
    if (cond_holds(instr[31:28], m_flags)) m_pc = m_pc + {{6{instr[23]}}, instr[23:0], 2'b00};
    return;
  end
  opc   = instr[24:21];
  a     = m_regs[instr[19:16]];
  b     = model_operand2(instr, m_regs[instr[3:0]]);
  x     = a;
  y     = b;
  sub   = 1'b0;
  k     = 1'b0;  // Carry in for adds, borrow for subtracts
  arith = 1'b1;
  case (opc)
    4'h2, 4'ha: sub = 1'b1;
    4'h3: begin x = b; y = a; sub = 1'b1; end
    4'h5: k = m_flags.c;
    4'h6: begin sub = 1'b1; k = !m_flags.c; end
    4'h7: begin x = b; y = a; sub = 1'b1; k = !m_flags.c; end
    4'h4, 4'hb: arith = 1'b1;
    default: arith = 1'b0;
  endcase
  if (sub) begin
    wide = {1'b0, x} - {1'b0, y} - 33'(k);
    sres = longint'($signed(x)) - longint'($signed(y)) - longint'(k);
  end else begin
    wide = {1'b0, x} + {1'b0, y} + 33'(k);
    sres = longint'($signed(x)) + longint'($signed(y)) + longint'(k);
  end
  case (opc)
    4'h0, 4'h8: res = a & b;
    4'h1, 4'h9: res = a ^ b;
    4'hc:       res = a | b;
    4'hd:       res = b;
    4'he:       res = a & ~b;
    4'hf:       res = ~b;
    default:    res = wide[31:0];
  endcase
  if (instr[20] || opc[3:2] == 2'b10) begin
    m_flags.n = res[31];
    m_flags.z = (res == '0);
    if (arith) begin
      m_flags.c = sub ? !wide[32] : wide[32];
      m_flags.v = (sres != longint'($signed(wide[31:0])));  // Result out of signed range
    end
  end
  if (opc[3:2] != 2'b10) begin
    m_regs[instr[15:12]] = res;
    m_writes.push_back('{rf_write: 1'b1, rd: instr[15:12], result: res});
  end
endfunction

function automatic ex_wb_t model_next_write();
  while (m_writes.size() == 0) model_step();
  return m_writes.pop_front();
endfunction

`endif

// ==== bench/arm_tb.sv ====
// Testbench for the pipelined core with a random program checked against an instruction model
module arm_tb;
  import arm_pkg::*;

  localparam int prog_words  = 256;
  localparam int seed        = 28;
  localparam int write_count = 500;
  localparam int clk_period  = 8;

  logic   clk;
  logic   reset;
  logic   fetch_valid;
  word_t  fetch_instr;
  word_t  fetch_addr;
  logic   wb_valid;
  ex_wb_t wb;

  word_t program_mem [prog_words];
  int    writes_seen;
  logic  started;
  int    quiet_edges;

  `include "arm_model.svh"

  arm_core #(.pc_reset('0)) dut0 (
    .clk, .reset, .fetch_valid, .fetch_instr,
    .fetch_addr, .wb_valid, .wb
  );

  assign fetch_instr = program_mem[fetch_addr[9:2]];  // Instruction memory lookup

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic reg_idx_t random_reg();
    if ($urandom_range(7) == 0) return 4'($urandom_range(15));
    return 4'($urandom_range(3));  // Mostly r0..r3 so operands collide
  endfunction

  function automatic word_t random_instr();
    logic [3:0] opc;
    logic       s;
    opc = 4'($urandom_range(15));
    s   = 1'($urandom_range(1));
    if ($urandom_range(99) < 20) begin
      return {4'($urandom_range(15)), 3'b101, 1'b0, 22'd0, 2'($urandom_range(3))};
    end
    if ($urandom_range(1) == 1) begin
      return {4'he, 2'b00, 1'b1, opc, s, random_reg(), random_reg(),
              4'($urandom_range(15)), 8'($urandom())};
    end
    return {4'he, 2'b00, 1'b0, opc, s, random_reg(), random_reg(),
            5'($urandom_range(31)), 2'($urandom_range(3)), 1'b0, random_reg()};
  endfunction

  // Samples outputs on the edge, before the DUT registers change
  always @(posedge clk) begin
    ex_wb_t exp_w;
    if (!reset) begin
      if (!started) begin
        check_value("idle fetch_addr", '0, fetch_addr);
        check_value("idle wb_valid", '0, 32'(wb_valid));
        if (fetch_valid) started = 1'b1;
      end else if (quiet_edges < 2) begin
        check_value("pipeline fill wb_valid", '0, 32'(wb_valid));
        quiet_edges++;
      end
      if (wb_valid && wb.rf_write) begin
        exp_w = model_next_write();
        check_value($sformatf("write %0d rd", writes_seen), 32'(exp_w.rd), 32'(wb.rd));
        check_value($sformatf("write %0d result", writes_seen), exp_w.result, wb.result);
        writes_seen++;
      end
    end
  end

  initial begin
    #(write_count * 20 * clk_period);
    abort_run($sformatf("Timeout with %0d of %0d writes seen", writes_seen, write_count));
  end

  initial begin
    void'($urandom(seed));
    for (int i = 0; i < prog_words; i++) begin
      program_mem[i] = random_instr();
    end
    model_reset();
    writes_seen = 0;
    started     = 1'b0;
    quiet_edges = 0;
    reset       = 1'b1;
    fetch_valid = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    fork
      forever begin
        @(posedge clk);
        fetch_valid <= ($urandom_range(3) != 0);  // About 75% of cycles
      end
    join_none
    wait (writes_seen == write_count);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
design/arm_pkg.sv
design/arm_fetch.sv
design/arm_pipe_reg.sv
design/arm_decode.sv
design/arm_regfile.sv
design/arm_forward.sv
design/arm_shifter.sv
design/arm_alu.sv
design/arm_branch_cond.sv
design/arm_core.sv
bench/arm_tb.sv

// ==== Makefile ====
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f vlog.f --top-module arm_tb --Mdir $(BUILD) -o arm_tb_sim
	./$(BUILD)/arm_tb_sim | tee $(LOG)
	@grep -q "^Simulation finished: PASS$$" $(LOG) || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
